/* cache_settings.svh */
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// total data storage in bytes
`define CACHE_SIZE_BYTES 8192

// one line is four 32-bit words
`define CACHE_LINE_BITS 128

// both bus ports
`define CACHE_ADDR_BITS 32

`endif

/* ahb_pkg.sv */
package ahb_pkg;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    typedef enum logic [2:0] {
        SINGLE = 3'b000,
        INCR   = 3'b001,
        WRAP4  = 3'b010
    } hburst_t;

    // address and control from the master plus write data
    typedef struct packed {
        logic [31:0] haddr;
        htrans_t     htrans;
        hburst_t     hburst;
        logic        hwrite;
        logic [31:0] hwdata;
    } ahb_req_t;

    typedef struct packed {
        logic        hready;
        logic [31:0] hrdata;
    } ahb_rsp_t;

endpackage

/* cache_pkg.sv */
package cache_pkg;

`include "cache_settings.svh"

    localparam int BYTE_BITS  = 2;
    localparam int LINE_WORDS = `CACHE_LINE_BITS / 32;
    localparam int OFF_BITS   = $clog2(LINE_WORDS);
    localparam int NUM_LINES  = `CACHE_SIZE_BYTES * 8 / `CACHE_LINE_BITS;
    localparam int INDEX_BITS = $clog2(NUM_LINES);
    localparam int TAG_BITS   = `CACHE_ADDR_BITS - INDEX_BITS - OFF_BITS - BYTE_BITS;
    localparam int WADDR_BITS = `CACHE_ADDR_BITS - BYTE_BITS;

    typedef logic [`CACHE_LINE_BITS-1:0] line_t;
    typedef logic [OFF_BITS-1:0]         word_off_t;
    typedef logic [INDEX_BITS-1:0]       index_t;
    typedef logic [TAG_BITS-1:0]         tag_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        line_t line;
    } entry_t;

    // line_base is a word address with the offset bits cleared
    typedef struct packed {
        logic [WADDR_BITS-1:0] line_base;
        word_off_t             start_word;
    } fill_req_t;

endpackage

/* cache_array.sv */
`timescale 1ns/100ps

module cache_array
    import cache_pkg::*;
(
    input  logic        upstream_intf,
    input  logic        rst_n,
    input  logic [31:0] lookup_addr,
    input  logic        fill_we,
    input  line_t       fill_line,
    output logic        hit,
    output logic [31:0] hit_word
);

    entry_t    entries [NUM_LINES];
    entry_t    sel_entry;
    tag_t      lk_tag;
    index_t    lk_index;
    word_off_t lk_off;

    // address split into tag, index, word and byte
    assign lk_tag   = lookup_addr[31 -: TAG_BITS];
    assign lk_index = lookup_addr[BYTE_BITS + OFF_BITS +: INDEX_BITS];
    assign lk_off   = lookup_addr[BYTE_BITS +: OFF_BITS];

    assign sel_entry = entries[lk_index];

    assign hit      = sel_entry.valid && (sel_entry.tag == lk_tag);
    assign hit_word = sel_entry.line[32 * lk_off +: 32];

    always_ff @(posedge upstream_intf) begin
        if (!rst_n) begin
            // only the valid bits are cleared
            for (int i = 0; i < NUM_LINES; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else if (fill_we) begin
            entries[lk_index].valid <= 1'b1;
            entries[lk_index].tag   <= lk_tag;
            entries[lk_index].line  <= fill_line;
        end
    end

endmodule

/* line_fill_master.sv */
`timescale 1ns/100ps

module line_fill_master
    import ahb_pkg::*;
    import cache_pkg::*;
(
    input  logic      upstream_intf,
    input  logic      rst_n,
    input  logic      fill_start,
    input  fill_req_t fill_req,
    output logic      fill_done,
    output line_t     fill_line,
    output ahb_req_t  dn_req,
    input  ahb_rsp_t  dn_rsp
);

    // beat whose data phase is on the bus
    typedef struct packed {
        logic      valid;
        word_off_t off;
        logic      last;
    } dphase_t;

    fill_req_t req_q;
    logic      a_active;
    logic [1:0] a_cnt;
    word_off_t a_off;
    dphase_t   dphase;
    line_t     line_buf;

    assign fill_line = line_buf;

    always_comb begin
        dn_req.htrans = IDLE;
        if (a_active) begin
            dn_req.htrans = (a_cnt == 2'd0) ? NONSEQ : SEQ;
        end
        dn_req.haddr  = {req_q.line_base[WADDR_BITS-1:OFF_BITS], a_off, {BYTE_BITS{1'b0}}};
        dn_req.hburst = WRAP4;
        dn_req.hwrite = 1'b0;
        dn_req.hwdata = '0;
    end

    always_ff @(posedge upstream_intf) begin
        if (!rst_n) begin
            a_active     <= 1'b0;
            a_cnt        <= '0;
            dphase.valid <= 1'b0;
            fill_done    <= 1'b0;
        end else begin
            fill_done <= 1'b0;
            if (fill_start) begin
                req_q    <= fill_req;
                a_active <= 1'b1;
                a_cnt    <= '0;
                a_off    <= fill_req.start_word;
            end else if (dn_rsp.hready) begin
                // data phase of the previous beat completes here
                if (dphase.valid) begin
                    line_buf[32 * dphase.off +: 32] <= dn_rsp.hrdata;
                    fill_done <= dphase.last;
                end
                dphase.valid <= a_active;
                dphase.off   <= a_off;
                dphase.last  <= (a_cnt == 2'd3);
                if (a_active) begin
                    // offset wraps inside the line
                    a_off    <= a_off + 1'b1;
                    a_cnt    <= a_cnt + 1'b1;
                    a_active <= (a_cnt != 2'd3);
                end
            end
        end
    end

endmodule

/* ahb_slave_port.sv */
`timescale 1ns/100ps

module ahb_slave_port
    import ahb_pkg::*;
    import cache_pkg::*;
(
    input  logic        upstream_intf,
    input  logic        rst_n,
    input  ahb_req_t    up_req,
    output ahb_rsp_t    up_rsp,
    output logic [31:0] lookup_addr,
    input  logic        hit,
    input  logic [31:0] hit_word,
    output logic        fill_start,
    output fill_req_t   fill_req,
    input  logic        fill_done,
    input  line_t       fill_line,
    output logic        fill_we
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_FILL,
        S_RESP
    } state_t;

    state_t      state;
    logic        dp_valid;
    logic [31:0] addr_q;
    logic        hready_int;
    logic        accept;
    word_off_t   word_sel;

    assign word_sel    = addr_q[BYTE_BITS +: OFF_BITS];
    assign lookup_addr = addr_q;

    // hwrite is ignored and every transfer is served as a read
    assign accept = hready_int && (up_req.htrans == NONSEQ || up_req.htrans == SEQ);

    always_comb begin
        case (state)
            S_IDLE:  hready_int = !dp_valid || hit;
            S_FILL:  hready_int = 1'b0;
            S_RESP:  hready_int = 1'b1;
            default: hready_int = 1'b1;
        endcase
    end

    assign up_rsp.hready = hready_int;
    assign up_rsp.hrdata = (state == S_RESP) ? fill_line[32 * word_sel +: 32] : hit_word;

    // miss detected in the data phase
    assign fill_start = (state == S_IDLE) && dp_valid && !hit;

    assign fill_req.line_base  = {addr_q[31:BYTE_BITS + OFF_BITS], {OFF_BITS{1'b0}}};
    assign fill_req.start_word = word_sel;

    assign fill_we = (state == S_FILL) && fill_done;

    always_ff @(posedge upstream_intf) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            dp_valid <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (fill_start) begin
                        state <= S_FILL;
                    end
                end
                S_FILL: begin
                    if (fill_done) begin
                        state <= S_RESP;
                    end
                end
                S_RESP: state <= S_IDLE;
                default: state <= S_IDLE;
            endcase

            // next address phase may overlap the finishing data phase
            if (accept) begin
                dp_valid <= 1'b1;
                addr_q   <= up_req.haddr;
            end else if (hready_int) begin
                dp_valid <= 1'b0;
            end
        end
    end

endmodule

/* cache_top.sv */
`timescale 1ns/100ps

module cache_top
    import ahb_pkg::*;
    import cache_pkg::*;
(
    input  logic     upstream_intf,
    input  logic     rst_n,
    input  ahb_req_t up_req,
    output ahb_rsp_t up_rsp,
    output ahb_req_t dn_req,
    input  ahb_rsp_t dn_rsp
);

    logic [31:0] lookup_addr;
    logic        hit;
    logic [31:0] hit_word;
    logic        fill_start;
    fill_req_t   fill_req;
    logic        fill_done;
    line_t       fill_line;
    logic        fill_we;

    ahb_slave_port u_slave_port (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .up_req        (up_req),
        .up_rsp        (up_rsp),
        .lookup_addr   (lookup_addr),
        .hit           (hit),
        .hit_word      (hit_word),
        .fill_start    (fill_start),
        .fill_req      (fill_req),
        .fill_done     (fill_done),
        .fill_line     (fill_line),
        .fill_we       (fill_we)
    );

    cache_array u_cache_array (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .lookup_addr   (lookup_addr),
        .fill_we       (fill_we),
        .fill_line     (fill_line),
        .hit           (hit),
        .hit_word      (hit_word)
    );

    line_fill_master u_fill_master (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .fill_start    (fill_start),
        .fill_req      (fill_req),
        .fill_done     (fill_done),
        .fill_line     (fill_line),
        .dn_req        (dn_req),
        .dn_rsp        (dn_rsp)
    );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n,
    input  logic reset_req
);

    localparam int RESET_CYCLES = 10;

    int rst_cnt = RESET_CYCLES;

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // reset held low until the counter runs out
    assign rst_n = (rst_cnt == 0);

    always @(posedge clk) begin
        if (reset_req) begin
            rst_cnt <= RESET_CYCLES;
        end else if (rst_cnt > 0) begin
            rst_cnt <= rst_cnt - 1;
        end
    end

endmodule

/* tb_ahb_mem.sv */
`timescale 1ns/100ps

module tb_ahb_mem
    import ahb_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  ahb_req_t    req,
    output ahb_rsp_t    rsp,
    output int unsigned burst_count
);

    localparam logic [31:0] DATA_KEY = 32'hC0DE_0000;
    localparam logic [31:0] SEED     = 32'd69501;

    logic        dp_valid = 1'b0;
    logic [31:0] dp_addr;
    logic [1:0]  wait_left = 2'd0;
    logic [31:0] lcg_state;
    logic [31:0] lcg_nxt;
    logic        take;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    assign lcg_nxt    = lcg_next(lcg_state);
    assign rsp.hready = !dp_valid || (wait_left == 2'd0);
    assign rsp.hrdata = dp_valid ? (dp_addr ^ DATA_KEY) : 32'h0;
    assign take       = rsp.hready && (req.htrans == NONSEQ || req.htrans == SEQ);

    always @(posedge clk) begin
        if (!rst_n) begin
            dp_valid    <= 1'b0;
            wait_left   <= 2'd0;
            lcg_state   <= SEED;
            burst_count <= 0;
        end else if (!rsp.hready) begin
            wait_left <= wait_left - 2'd1;
        end else begin
            dp_valid <= take;
            if (take) begin
                dp_addr   <= req.haddr;
                // top bits of the lcg give 0 to 3 wait states
                wait_left <= lcg_nxt[31:30];
                lcg_state <= lcg_nxt;
                if (req.htrans == NONSEQ) begin
                    burst_count <= burst_count + 1;
                end
            end
        end
    end

endmodule

/* tb_cache.sv */
`timescale 1ns/100ps

module tb_cache
    import ahb_pkg::*;
();

    localparam int PIPE_TEST      = 5;
    localparam int RESET_TEST     = 6;
    localparam int TIMEOUT_CYCLES = 200;
    localparam int IDLE_CYCLES    = 8;

    logic        clk;
    logic        rst_n;
    logic        reset_req;
    ahb_req_t    up_req;
    ahb_rsp_t    up_rsp;
    ahb_req_t    dn_req;
    ahb_rsp_t    dn_rsp;
    int unsigned burst_count;

    logic [31:0] up_addr_q;
    logic [31:0] dn_addr_q;

    int          st_test[$];
    logic [31:0] st_addr[$];
    logic [31:0] st_data[$];
    int          st_bursts[$];

    int n_tests;
    int n_checks;
    int n_fail;
    int test_fail;
    bit aborted;

    tb_clock_gen u_clock_gen (.clk(clk), .rst_n(rst_n), .reset_req(reset_req));

    cache_top dut0 (
        .upstream_intf (clk),
        .rst_n         (rst_n),
        .up_req        (up_req),
        .up_rsp        (up_rsp),
        .dn_req        (dn_req),
        .dn_rsp        (dn_rsp)
    );

    tb_ahb_mem u_mem (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (dn_req),
        .rsp         (dn_rsp),
        .burst_count (burst_count)
    );

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_fail++;
            test_fail++;
            $display("[FAIL] %0t: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // downstream beats walk the line in WRAP4 order from the missed word
    always @(posedge clk) begin
        if (rst_n === 1'b1 && dn_rsp.hready === 1'b1) begin
            if (dn_req.htrans == NONSEQ) begin
                compare_value("downstream burst type", dn_req.hburst, WRAP4);
                compare_value("downstream hwrite", dn_req.hwrite, 1'b0);
                compare_value("downstream start address", dn_req.haddr,
                              {up_addr_q[31:2], 2'b00});
                dn_addr_q <= dn_req.haddr;
            end else if (dn_req.htrans == SEQ) begin
                compare_value("downstream burst type", dn_req.hburst, WRAP4);
                compare_value("downstream hwrite", dn_req.hwrite, 1'b0);
                compare_value("downstream wrap address", dn_req.haddr,
                              {dn_addr_q[31:4], dn_addr_q[3:2] + 2'd1, 2'b00});
                dn_addr_q <= dn_req.haddr;
            end
        end
        if (rst_n === 1'b1 && up_rsp.hready === 1'b1 && up_req.htrans == NONSEQ) begin
            up_addr_q <= up_req.haddr;
        end
    end

    task automatic load_stimulus();
        int          fd;
        int          t;
        int          b;
        logic [31:0] a;
        logic [31:0] d;
        string       line;
        fd = $fopen("cache_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file cache_stim.txt");
            aborted = 1;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            // comment lines do not scan as four fields
            if ($fgets(line, fd) > 0 && $sscanf(line, "%d %h %h %d", t, a, d, b) == 4) begin
                st_test.push_back(t);
                st_addr.push_back(a);
                st_data.push_back(d);
                st_bursts.push_back(b);
            end
        end
        $fclose(fd);
        if (st_test.size() == 0) begin
            $display("the stimulus file holds no reads");
            aborted = 1;
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            $display("timeout: reset was never released");
            aborted = 1;
        end
    endtask

    // an idle cache keeps hready high and starts no burst
    task automatic check_idle_bus(input int cycles);
        for (int k = 0; k < cycles; k++) begin
            compare_value("hready after reset", up_rsp.hready, 1'b1);
            compare_value("downstream htrans after reset", dn_req.htrans, IDLE);
            @(negedge clk);
        end
        compare_value("burst count after reset", burst_count, 0);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset_req <= 1'b1;
        @(posedge clk);
        reset_req <= 1'b0;
        @(negedge clk);
        wait_reset_release();
    endtask

    // next address may go out while the previous read is in its data phase
    task automatic run_reads(input int first, input int last, input bit pipelined);
        int    a_idx;
        int    bus_idx;
        int    dp_idx;
        int    done;
        int    cycles;
        string tag;
        a_idx   = first;
        bus_idx = -1;
        dp_idx  = -1;
        done    = 0;
        cycles  = 0;
        while (done < last - first + 1 && !aborted) begin
            @(negedge clk);
            cycles++;
            if (up_rsp.hready === 1'b1) begin
                if (dp_idx >= 0) begin
                    tag = $sformatf("read %h", st_addr[dp_idx]);
                    compare_value({tag, " data"}, up_rsp.hrdata, st_data[dp_idx]);
                    compare_value({tag, " bursts"}, burst_count, st_bursts[dp_idx]);
                    done++;
                    cycles = 0;
                end
                dp_idx  = bus_idx;
                bus_idx = -1;
                if (a_idx <= last && (pipelined || dp_idx < 0)) begin
                    bus_idx = a_idx;
                    a_idx++;
                end
            end
            if (cycles > TIMEOUT_CYCLES) begin
                $display("timeout: read %0d got no response from the cache", dp_idx);
                aborted = 1;
            end
            @(posedge clk);
            if (bus_idx >= 0) begin
                up_req.haddr  <= st_addr[bus_idx];
                up_req.htrans <= NONSEQ;
            end else begin
                up_req.htrans <= IDLE;
            end
        end
    endtask

    task automatic report_test(input int num, input int reads);
        n_tests++;
        $display("test %0d finished: %0d reads, %0d mismatches", num, reads, test_fail);
    endtask

    initial begin
        int i;
        int j;
        reset_req = 1'b0;
        up_req    = '0;
        aborted   = 0;
        n_tests   = 0;
        n_checks  = 0;
        n_fail    = 0;
        test_fail = 0;
        load_stimulus();
        if (!aborted) begin
            wait_reset_release();
        end
        if (!aborted) begin
            test_fail = 0;
            check_idle_bus(IDLE_CYCLES);
            report_test(1, 0);
        end
        i = 0;
        while (i < st_test.size() && !aborted) begin
            j = i;
            while (j + 1 < st_test.size() && st_test[j + 1] == st_test[i]) begin
                j++;
            end
            test_fail = 0;
            if (st_test[i] == RESET_TEST) begin
                apply_reset();
            end
            if (!aborted) begin
                run_reads(i, j, st_test[i] == PIPE_TEST);
            end
            if (!aborted) begin
                report_test(st_test[i], j - i + 1);
            end
            i = j + 1;
        end
        $display("tests: %0d, checks: %0d, mismatches: %0d", n_tests, n_checks, n_fail);
        if (!aborted && n_fail == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* cache_stim.txt */
// test  address(hex)  expected_data(hex)  bursts_after_read(dec)
// test 5 runs pipelined, test 6 starts with a fresh reset
2 00000100 c0de0100 1
2 0000024c c0de024c 2
3 00000100 c0de0100 2
3 00000104 c0de0104 2
3 00000108 c0de0108 2
3 0000010c c0de010c 2
3 00000240 c0de0240 2
3 00000244 c0de0244 2
3 00000248 c0de0248 2
4 00002104 c0de2104 3
4 0000210c c0de210c 3
4 00000108 c0de0108 4
4 00002100 c0de2100 5
4 12340248 d2ea0248 6
5 00002108 c0de2108 6
5 00000400 c0de0400 7
5 00000404 c0de0404 7
5 00000100 c0de0100 8
5 0000040c c0de040c 8
5 0000058c c0de058c 9
5 00000580 c0de0580 9
5 00000104 c0de0104 9
5 00001ff8 c0de1ff8 10
5 00001ff0 c0de1ff0 10
5 abcd0404 6b130404 11
5 00000408 c0de0408 12
5 abcd0400 6b130400 13
6 00000104 c0de0104 1
6 00000100 c0de0100 1
6 00001ffc c0de1ffc 2
6 0000058c c0de058c 3

/* project.f */
+incdir+.
ahb_pkg.sv
cache_pkg.sv
cache_array.sv
line_fill_master.sv
ahb_slave_port.sv
cache_top.sv
tb_clock_gen.sv
tb_ahb_mem.sv
tb_cache.sv

/* Bender.yml */
package:
  name: ahb_line_cache

export_include_dirs:
  - .

sources:
  - files:
      - ahb_pkg.sv
      - cache_pkg.sv
      - cache_array.sv
      - line_fill_master.sv
      - ahb_slave_port.sv
      - cache_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_ahb_mem.sv
      - tb_cache.sv
